//--- common/acq_config.svh
`ifndef ACQ_CONFIG_SVH
`define ACQ_CONFIG_SVH

//////////////////////////////
// acquisition sizes
//////////////////////////////

`define ADC_DW        14  // adc sample width
`define ACQ_LEN       16  // samples per trigger, even
`define WORD_AW       4   // word index bits inside one scope region

//////////////////////////////
// flow control
//////////////////////////////

`define PORT_CREDITS  4   // queue depth per scope port
`define MEM_CREDITS   4   // external write port credits after reset
`define N_SCOPE       2   // scope units sharing the write port

`endif

//--- common/acq_pkg.sv
`include "acq_config.svh"

package acq_pkg;

  //////////////////////////////
  // adc side
  //////////////////////////////

  localparam int unsigned N_CH = 2;  // adc channels on the board

  // raw pad word, unsigned with negative slope
  typedef logic [`ADC_DW-1:0] adc_raw_t;

  // decoded sample, two's complement
  typedef logic signed [`ADC_DW-1:0] sample_t;

  // decoder output, one sample per channel
  typedef struct packed {
    sample_t [N_CH-1:0] ch;  // ch[0] is channel 0
  } sample_pair_t;

  //////////////////////////////
  // scope unit control
  //////////////////////////////

  // per-unit configuration, normally from registers
  typedef struct packed {
    logic    spare;     // reserved
    logic    src_peer;  // 0 own level, 1 peer trigger
    sample_t thresh;    // signed level threshold
  } scope_cfg_t;

  // per-unit status
  typedef struct packed {
    logic armed;      // waiting for trigger or capturing
    logic capturing;  // samples being taken
    logic overflow;   // sticky, a word was dropped
  } scope_stat_t;

endpackage

//--- common/mem_pkg.sv
`include "acq_config.svh"

package mem_pkg;

  //////////////////////////////
  // memory word
  //////////////////////////////

  localparam int unsigned HALF_W = 16;            // one sample slot
  localparam int unsigned ADDR_W = `WORD_AW + 1;  // scope number on top

  typedef logic [HALF_W-1:0] half_t;

  // two sign-extended samples, earlier one in the low half
  typedef struct packed {
    half_t late;   // bits 31:16
    half_t early;  // bits 15:0
  } mem_word_t;

  //////////////////////////////
  // write paths
  //////////////////////////////

  // scope unit to arbiter, one push per valid cycle
  typedef struct packed {
    logic                valid;
    logic [`WORD_AW-1:0] idx;   // word index in the capture
    mem_word_t           data;
  } port_req_t;

  // arbiter to external memory
  typedef struct packed {
    logic              valid;  // spends one external credit
    logic [ADDR_W-1:0] addr;   // {scope, word index}
    mem_word_t         data;
  } mem_wr_t;

endpackage

//--- rtl/adc_decode.sv
`timescale 1ns/1ps
`include "acq_config.svh"

module adc_decode (
  input  logic                                      adc_clk,
  input  logic                                      rst_n_i,
  input  acq_pkg::adc_raw_t [acq_pkg::N_CH-1:0]     adc_raw_i,  // straight from pads
  output acq_pkg::sample_pair_t                     samples_o
);

//////////////////////////////
// code conversion
//////////////////////////////

// the adc delivers unsigned code with negative slope
// keeping msb and inverting the rest gives two's complement
function automatic acq_pkg::sample_t to_signed(acq_pkg::adc_raw_t raw);
  return {raw[`ADC_DW-1], ~raw[`ADC_DW-2:0]};
endfunction

acq_pkg::sample_pair_t dec;  // combinational result

always_comb begin
  for (int i = 0; i < acq_pkg::N_CH; i++) begin
    dec.ch[i] = to_signed(adc_raw_i[i]);  // per channel
  end
end

//////////////////////////////
// output register
//////////////////////////////

// single register stage, the only timing point after the pads
always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    samples_o <= '0;
  end else begin
    samples_o <= dec;
  end
end

endmodule

//--- scope/scope_capture.sv
`timescale 1ns/1ps
`include "acq_config.svh"

module scope_capture #(
  parameter int unsigned CH = 0  // channel of the pair this unit watches
) (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  acq_pkg::sample_pair_t samples_i,
  input  acq_pkg::scope_cfg_t   cfg_i,
  input  logic                  arm_i,
  input  logic                  peer_trig_i,  // from the other unit
  output logic                  trig_o,       // own level trigger only
  input  logic                  credit_i,     // one slot freed in arbiter queue
  output mem_pkg::port_req_t    req_o,
  output acq_pkg::scope_stat_t  stat_o
);

localparam int unsigned CW = $clog2(`ACQ_LEN);        // sample counter
localparam int unsigned KW = $clog2(`PORT_CREDITS + 1);

acq_pkg::sample_t    cur;         // current sample of our channel
acq_pkg::sample_t    prev_q;      // for edge detect
acq_pkg::sample_t    hold_q;      // even sample waiting for its partner
logic                armed_q;
logic                capt_q;
logic                ovf_q;
logic [CW-1:0]       cnt_q;       // index of next sample
logic [CW-1:0]       smp_idx;     // index of the sample taken now
logic [KW-1:0]       cred_q;      // free slots in our arbiter queue
logic                level_hit;
logic                start;
logic                take;
logic                last;
logic                pair_done;
logic                push;
logic                req_vld_q;
logic [`WORD_AW-1:0] idx_q;
mem_pkg::mem_word_t  word_q;

function automatic mem_pkg::half_t sext(acq_pkg::sample_t s);
  return {{(mem_pkg::HALF_W-`ADC_DW){s[`ADC_DW-1]}}, s};
endfunction

//////////////////////////////
// trigger
//////////////////////////////

assign cur = samples_i.ch[CH];

// rising crossing, previous below and current at or above
assign level_hit = ($signed(prev_q) < $signed(cfg_i.thresh)) &&
                   ($signed(cur) >= $signed(cfg_i.thresh));

assign start  = armed_q && !capt_q && (cfg_i.src_peer ? peer_trig_i : level_hit);
assign trig_o = armed_q && !capt_q && !cfg_i.src_peer && level_hit;

//////////////////////////////
// capture and packing
//////////////////////////////

assign take      = start || capt_q;            // a sample is taken this cycle
assign smp_idx   = capt_q ? cnt_q : '0;         // trigger sample is sample 0
assign last      = capt_q && (cnt_q == CW'(`ACQ_LEN - 1));
assign pair_done = capt_q && cnt_q[0];          // odd sample closes a word
assign push      = pair_done && (cred_q != '0);  // no credit, no push

always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    armed_q   <= 1'b0;
    capt_q    <= 1'b0;
    ovf_q     <= 1'b0;
    cnt_q     <= '0;
    cred_q    <= KW'(`PORT_CREDITS);
    req_vld_q <= 1'b0;
  end else begin
    if (last) begin
      armed_q <= 1'b0;  // capture done
      capt_q  <= 1'b0;
    end else begin
      if (arm_i && !capt_q) armed_q <= 1'b1;  // arm ignored while capturing
      if (start) capt_q <= 1'b1;
    end
    cnt_q  <= (take && !last) ? smp_idx + 1'b1 : '0;
    cred_q <= cred_q - KW'(push) + KW'(credit_i);
    if (pair_done && !push) ovf_q <= 1'b1;  // word dropped, sticky
    req_vld_q <= push;
  end
end

// payload, valid qualifies it
always_ff @(posedge adc_clk) begin
  prev_q <= cur;
  if (take && !smp_idx[0]) hold_q <= cur;
  if (pair_done) begin
    idx_q        <= `WORD_AW'(cnt_q[CW-1:1]);  // index advances even on drop
    word_q.early <= sext(hold_q);
    word_q.late  <= sext(cur);
  end
end

assign req_o  = '{valid: req_vld_q, idx: idx_q, data: word_q};
assign stat_o = '{armed: armed_q, capturing: capt_q, overflow: ovf_q};

endmodule

//--- scope/scope_wr_arbiter.sv
`timescale 1ns/1ps
`include "acq_config.svh"

module scope_wr_arbiter (
  input  logic                               adc_clk,
  input  logic                               rst_n_i,
  input  mem_pkg::port_req_t [`N_SCOPE-1:0]  req_i,
  output logic               [`N_SCOPE-1:0]  credit_o,      // pulse per popped word
  output mem_pkg::mem_wr_t                   mem_wr_o,
  input  logic                               mem_credit_i   // one credit back
);

localparam int unsigned N  = `N_SCOPE;
localparam int unsigned D  = `PORT_CREDITS;
localparam int unsigned PW = $clog2(N);
localparam int unsigned AW = $clog2(D);
localparam int unsigned CW = $clog2(D + 1);
localparam int unsigned MW = $clog2(`MEM_CREDITS + 1);

logic [`WORD_AW-1:0] q_idx [N][D];  // queued word indices
mem_pkg::mem_word_t  q_dat [N][D];  // queued words
logic [AW-1:0]       wr_ptr_q [N];
logic [AW-1:0]       rd_ptr_q [N];
logic [CW-1:0]       q_cnt_q [N];
logic [N-1:0]        nonempty;
logic [PW-1:0]       last_q;        // port served last
logic [PW-1:0]       sel;
logic                any;
logic                pop;
logic [MW-1:0]       mem_cred_q;    // external credits left

//////////////////////////////
// per-port queues
//////////////////////////////

for (genvar g = 0; g < N; g++) begin : g_port
  logic push;
  logic take;

  assign push        = req_i[g].valid;  // sender holds a credit
  assign take        = pop && (sel == PW'(g));
  assign credit_o[g] = take;
  assign nonempty[g] = (q_cnt_q[g] != '0);

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q[g] <= '0;
      rd_ptr_q[g] <= '0;
      q_cnt_q[g]  <= '0;
    end else begin
      if (push) wr_ptr_q[g] <= (wr_ptr_q[g] == AW'(D - 1)) ? '0 : wr_ptr_q[g] + 1'b1;
      if (take) rd_ptr_q[g] <= (rd_ptr_q[g] == AW'(D - 1)) ? '0 : rd_ptr_q[g] + 1'b1;
      q_cnt_q[g] <= q_cnt_q[g] + CW'(push) - CW'(take);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (push) begin
      q_idx[g][wr_ptr_q[g]] <= req_i[g].idx;
      q_dat[g][wr_ptr_q[g]] <= req_i[g].data;
    end
  end
end

//////////////////////////////
// round robin pick
//////////////////////////////

// search starts one past the last served port
always_comb begin : rr_pick
  logic [PW-1:0] p;
  p   = last_q;
  sel = last_q;
  any = 1'b0;
  for (int i = 1; i <= N; i++) begin
    p = PW'((int'(last_q) + i) % N);
    if (!any && nonempty[p]) begin
      sel = p;
      any = 1'b1;
    end
  end
end

assign pop = any && (mem_cred_q != '0);  // write only with a credit in hand

// head of the selected queue, port number above the word index
assign mem_wr_o = '{valid: pop,
                    addr:  {sel, q_idx[sel][rd_ptr_q[sel]]},
                    data:  q_dat[sel][rd_ptr_q[sel]]};

always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    last_q     <= PW'(N - 1);  // port 0 first
    mem_cred_q <= MW'(`MEM_CREDITS);
  end else begin
    if (pop) last_q <= sel;
    mem_cred_q <= mem_cred_q - MW'(pop) + MW'(mem_credit_i);
  end
end

endmodule

//--- rtl/acq_top.sv
`timescale 1ns/1ps
`include "acq_config.svh"

module acq_top (
  input  logic                                      adc_clk,
  input  logic                                      rst_n_i,
  input  acq_pkg::adc_raw_t    [acq_pkg::N_CH-1:0]  adc_raw_i,
  input  logic                 [`N_SCOPE-1:0]       arm_i,
  input  acq_pkg::scope_cfg_t  [`N_SCOPE-1:0]       cfg_i,
  output acq_pkg::scope_stat_t [`N_SCOPE-1:0]       stat_o,
  output mem_pkg::mem_wr_t                          mem_wr_o,
  input  logic                                      mem_credit_i
);

acq_pkg::sample_pair_t             samples;  // decoded, both channels
logic [`N_SCOPE-1:0]               trig;     // level triggers, crossed to peer
logic [`N_SCOPE-1:0]               credit;   // arbiter to unit
mem_pkg::port_req_t [`N_SCOPE-1:0] req;      // unit to arbiter

//////////////////////////////
// adc decode
//////////////////////////////

adc_decode adc_decode_inst (
  .adc_clk   (adc_clk  ),
  .rst_n_i   (rst_n_i  ),
  .adc_raw_i (adc_raw_i),
  .samples_o (samples  )
);

//////////////////////////////
// scope units
//////////////////////////////

// unit g watches channel g, peer is the other unit
for (genvar g = 0; g < `N_SCOPE; g++) begin : g_scope
  scope_capture #(
    .CH (g)
  ) scope_capture_inst (
    .adc_clk     (adc_clk              ),
    .rst_n_i     (rst_n_i              ),
    .samples_i   (samples              ),  // whole pair to each unit
    .cfg_i       (cfg_i[g]             ),
    .arm_i       (arm_i[g]             ),
    .peer_trig_i (trig[`N_SCOPE-1-g]   ),  // cross trigger
    .trig_o      (trig[g]              ),
    .credit_i    (credit[g]            ),
    .req_o       (req[g]               ),
    .stat_o      (stat_o[g]            )
  );
end

//////////////////////////////
// memory write arbiter
//////////////////////////////

scope_wr_arbiter scope_wr_arbiter_inst (
  .adc_clk      (adc_clk     ),
  .rst_n_i      (rst_n_i     ),
  .req_i        (req         ),
  .credit_o     (credit      ),
  .mem_wr_o     (mem_wr_o    ),  // shared external port
  .mem_credit_i (mem_credit_i)
);

endmodule

//--- verif/acq_assertions.sv
`timescale 1ns/1ps
`include "acq_config.svh"

module acq_assertions (
  input logic                                 adc_clk,
  input logic                                 rst_n_i,
  input mem_pkg::mem_wr_t                     mem_wr_i,      // arbiter output
  input logic [$clog2(`MEM_CREDITS + 1)-1:0]  mem_cred_i,    // external credit count
  input logic                                 mem_credit_i,  // credit back from outside
  input logic [`N_SCOPE-1:0]                  credit_i,      // credit pulses to units
  input logic [`N_SCOPE-1:0]                  nonempty_i     // queue state per port
);

localparam int unsigned MW = $clog2(`MEM_CREDITS + 1);

logic [MW-1:0] port_cred;  // credits counted at the port pins

always_ff @(posedge adc_clk or negedge rst_n_i) begin
  if (!rst_n_i) begin
    port_cred <= MW'(`MEM_CREDITS);
  end else begin
    port_cred <= port_cred - MW'(mem_wr_i.valid) + MW'(mem_credit_i);
  end
end

//////////////////////////////
// external credit
//////////////////////////////

// a write spends a credit, so one must be there
a_write_has_credit : assert property (
  @(posedge adc_clk) disable iff (!rst_n_i)
  mem_wr_i.valid |-> (port_cred != '0)
) else $error("write issued with no external credit");

// returns never push the count past its reset value
a_credit_bound : assert property (
  @(posedge adc_clk) disable iff (!rst_n_i)
  mem_cred_i <= `MEM_CREDITS
) else $error("external credit count above its maximum");

//////////////////////////////
// port credits
//////////////////////////////

a_credit_from_queue : assert property (
  @(posedge adc_clk) disable iff (!rst_n_i)
  (credit_i & ~nonempty_i) == '0  // pop only from a filled queue
) else $error("credit pulse on a port with an empty queue");

endmodule

//--- verif/acq_tb.sv
`timescale 1ns/1ps
`include "acq_config.svh"

module acq_tb;

localparam int NW         = `ACQ_LEN / 2;                // words per capture
localparam int RW         = 1 << `WORD_AW;               // word slots in one scope region
localparam int NA         = `N_SCOPE * RW;               // address slots
localparam int NT         = `N_SCOPE * NW;               // words when every unit captures
localparam int CAPT_CYC   = 300;                         // bound for one capture run
localparam int N_RUNS     = 6;
localparam int WATCHDOG_NS = N_RUNS * CAPT_CYC * 8 + 2000;

logic                                     adc_clk = 1'b0;
logic                                     rst_n_i;
acq_pkg::adc_raw_t    [acq_pkg::N_CH-1:0] adc_raw_i;
logic                 [`N_SCOPE-1:0]      arm_i;
acq_pkg::scope_cfg_t  [`N_SCOPE-1:0]      cfg_i;
acq_pkg::scope_stat_t [`N_SCOPE-1:0]      stat_o;
mem_pkg::mem_wr_t                         mem_wr_o;
logic                                     mem_credit_i;

integer             seed = 32'h84b;
int                 clr_gen = 0;      // bumped to clear the expected set
logic               hold_credits = 1'b0;
mem_pkg::mem_word_t exp_word [NA];    // model words by address
bit                 exp_ok [NA];
int                 exp_cnt;
int                 m_gen;
bit                 rcv [NA];         // addresses already written
int                 rcv_cnt;
int                 r_gen;
int                 owed;             // external credits not yet returned

always #4 adc_clk = ~adc_clk;

acq_top acq_top_inst (.*);

bind scope_wr_arbiter acq_assertions acq_assertions_inst (
  .adc_clk      (adc_clk     ),
  .rst_n_i      (rst_n_i     ),
  .mem_wr_i     (mem_wr_o    ),
  .mem_cred_i   (mem_cred_q  ),
  .mem_credit_i (mem_credit_i),
  .credit_i     (credit_o    ),
  .nonempty_i   (nonempty    )
);

//////////////////////////////
// reporting and compares
//////////////////////////////

task automatic report_error(string msg);
  $display("%s", msg);
  $display("Simulation FAILED");
  $fatal(1);
endtask

task automatic compare_wr(string name, mem_pkg::mem_wr_t exp, mem_pkg::mem_wr_t act);
  if (exp !== act)
    report_error($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
endtask

task automatic compare_stat(string name, acq_pkg::scope_stat_t exp,
                            acq_pkg::scope_stat_t act);
  if (exp !== act)
    report_error($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
endtask

initial begin : watchdog
  #(WATCHDOG_NS);
  report_error("timeout, the test sequence did not finish in time");
end

//////////////////////////////
// reference model
//////////////////////////////

function automatic acq_pkg::sample_t decode_raw(acq_pkg::adc_raw_t r);
  return acq_pkg::sample_t'(r ^ 14'h1fff);  // msb kept, rest inverted
endfunction

function automatic mem_pkg::half_t widen(acq_pkg::sample_t s);
  return {{2{s[13]}}, s};
endfunction

acq_pkg::sample_t m_cur [2];   // decoded sample seen by the units
acq_pkg::sample_t m_prev [2];
acq_pkg::sample_t m_hold [2];
bit               m_armed [2];
bit               m_capt [2];
int               m_cnt [2];

always @(posedge adc_clk or negedge rst_n_i) begin : model
  bit hit [2];
  bit ltrig [2];
  bit strt [2];
  int idx;
  int a;
  if (!rst_n_i) begin
    for (int u = 0; u < 2; u++) begin
      m_cur[u] = '0;
      m_armed[u] = 0;
      m_capt[u] = 0;
      m_cnt[u] = 0;
    end
  end else begin
    if (clr_gen != m_gen) begin  // new test, forget old words
      for (int i = 0; i < NA; i++) exp_ok[i] = 0;
      exp_cnt = 0;
      m_gen = clr_gen;
    end
    for (int u = 0; u < 2; u++) begin
      hit[u] = m_armed[u] && !m_capt[u] && (m_prev[u] < cfg_i[u].thresh) &&
               (m_cur[u] >= cfg_i[u].thresh);
      ltrig[u] = hit[u] && !cfg_i[u].src_peer;
    end
    for (int u = 0; u < 2; u++)
      strt[u] = m_armed[u] && !m_capt[u] && (cfg_i[u].src_peer ? ltrig[1-u] : hit[u]);
    for (int u = 0; u < 2; u++) begin
      if (arm_i[u] && !m_capt[u]) m_armed[u] = 1;
      if (strt[u] || m_capt[u]) begin
        idx = m_capt[u] ? m_cnt[u] : 0;
        if (idx % 2 == 0) begin
          m_hold[u] = m_cur[u];
        end else begin
          a = u * RW + idx / 2;  // scope number above word index
          exp_word[a] = {widen(m_cur[u]), widen(m_hold[u])};
          exp_ok[a] = 1;
          exp_cnt++;
        end
        if (idx == `ACQ_LEN - 1) begin
          m_capt[u] = 0;
          m_armed[u] = 0;
          m_cnt[u] = 0;
        end else begin
          m_capt[u] = 1;
          m_cnt[u] = idx + 1;
        end
      end
      m_prev[u] = m_cur[u];
      m_cur[u] = decode_raw(adc_raw_i[u]);  // one cycle decode delay
    end
  end
end

//////////////////////////////
// adc stimulus
//////////////////////////////

initial begin : ramp_gen
  int ramp [2];
  int step [2];
  int noise;
  acq_pkg::sample_t s;
  ramp[0] = 0;
  ramp[1] = -5000;
  step[0] = 150;  // different slopes per channel
  step[1] = 110;
  adc_raw_i = '0;
  forever begin
    @(negedge adc_clk);
    for (int c = 0; c < 2; c++) begin
      ramp[c] = ramp[c] + step[c];
      if (ramp[c] > 8191) ramp[c] = ramp[c] - 16384;
      noise = $random(seed) % 16;
      s = acq_pkg::sample_t'(ramp[c] + noise);
      adc_raw_i[c] = acq_pkg::adc_raw_t'(s) ^ 14'h1fff;  // back to pad code
    end
  end
end

//////////////////////////////
// write checker and credits
//////////////////////////////

initial begin : write_check
  mem_pkg::mem_wr_t exp;
  int a;
  mem_credit_i = 1'b0;
  owed = 0;
  rcv_cnt = 0;
  r_gen = 0;
  forever begin
    @(negedge adc_clk);
    if (r_gen != clr_gen) begin
      for (int i = 0; i < NA; i++) rcv[i] = 0;
      rcv_cnt = 0;
      r_gen = clr_gen;
    end
    if (rst_n_i && mem_wr_o.valid) begin
      a = int'(mem_wr_o.addr);
      if (a >= NA || !exp_ok[a])
        report_error($sformatf("write to address %0d that no capture produced", a));
      if (rcv[a])
        report_error($sformatf("address %0d written a second time", a));
      exp = '{valid: 1'b1, addr: mem_wr_o.addr, data: exp_word[a]};
      compare_wr("mem_wr_o", exp, mem_wr_o);
      rcv[a] = 1;
      rcv_cnt++;
      owed++;
    end
    if (!hold_credits && owed > 0) begin  // one credit back per cycle
      mem_credit_i = 1'b1;
      owed--;
    end else begin
      mem_credit_i = 1'b0;
    end
  end
end

//////////////////////////////
// test sequence
//////////////////////////////

task automatic new_test(logic peer1);
  clr_gen++;
  cfg_i[0] = '{spare: 1'b0, src_peer: 1'b0, thresh: acq_pkg::sample_t'($random(seed) % 2000)};
  cfg_i[1] = '{spare: 1'b0, src_peer: peer1, thresh: acq_pkg::sample_t'($random(seed) % 2000)};
  repeat (2) @(negedge adc_clk);
endtask

task automatic arm_units(logic [1:0] mask, logic ovf);
  arm_i = mask;
  @(negedge adc_clk);
  arm_i = '0;
  for (int u = 0; u < 2; u++)
    if (mask[u])
      compare_stat($sformatf("stat_o[%0d]", u), '{1'b1, 1'b0, ovf}, stat_o[u]);
endtask

task automatic wait_done(logic [1:0] mask, int words);
  do @(negedge adc_clk);
  while ((mask[0] && stat_o[0].armed) || (mask[1] && stat_o[1].armed) || rcv_cnt != exp_cnt);
  if (exp_cnt != words)
    report_error($sformatf("capture produced %0d words instead of %0d", exp_cnt, words));
  for (int u = 0; u < 2; u++)
    compare_stat($sformatf("stat_o[%0d]", u), '{1'b0, 1'b0, 1'b0}, stat_o[u]);
endtask

initial begin : sequencer
  int quiet;
  bit miss [2];
  rst_n_i = 1'b0;
  arm_i = '0;
  cfg_i = '0;
  repeat (2) @(negedge adc_clk);
  rst_n_i = 1'b1;
  for (int u = 0; u < 2; u++)
    compare_stat($sformatf("stat_o[%0d]", u), '{1'b0, 1'b0, 1'b0}, stat_o[u]);
  // own level capture on scope 0
  new_test(1'b0);
  arm_units(2'b01, 1'b0);
  wait_done(2'b01, NW);
  // scope 1 follows scope 0's trigger
  new_test(1'b1);
  arm_units(2'b11, 1'b0);
  wait_done(2'b11, NT);
  // both on their own levels
  new_test(1'b0);
  arm_units(2'b11, 1'b0);
  wait_done(2'b11, NT);
  // second arm after a finished capture
  new_test(1'b0);
  arm_units(2'b01, 1'b0);
  wait_done(2'b01, NW);
  // back-pressure, credits held through the capture
  new_test(1'b1);
  hold_credits = 1'b1;
  arm_units(2'b11, 1'b0);
  do @(negedge adc_clk);
  while (stat_o[0].armed || stat_o[1].armed);
  hold_credits = 1'b0;
  quiet = 0;
  while (quiet < 4) begin  // queues drained once writes stop
    @(negedge adc_clk);
    if (mem_wr_o.valid || owed != 0) quiet = 0;
    else quiet++;
  end
  if (rcv_cnt >= exp_cnt)
    report_error("no word was dropped while credits were withheld");
  for (int u = 0; u < 2; u++) begin
    miss[u] = 0;
    for (int k = 0; k < NW; k++)
      if (exp_ok[u * RW + k] && !rcv[u * RW + k]) miss[u] = 1;
    compare_stat($sformatf("stat_o[%0d]", u), '{1'b0, 1'b0, miss[u]}, stat_o[u]);
  end
  // reset clears the sticky overflow
  rst_n_i = 1'b0;
  repeat (2) @(negedge adc_clk);
  rst_n_i = 1'b1;
  for (int u = 0; u < 2; u++)
    compare_stat($sformatf("stat_o[%0d]", u), '{1'b0, 1'b0, 1'b0}, stat_o[u]);
  if (mem_wr_o.valid !== 1'b0)
    report_error("write valid is high right after reset");
  $display("Simulation PASSED");
  $finish;
end

endmodule

//--- tb.f
+incdir+common
common/acq_pkg.sv
common/mem_pkg.sv
rtl/adc_decode.sv
scope/scope_capture.sv
scope/scope_wr_arbiter.sv
rtl/acq_top.sv
verif/acq_assertions.sv
verif/acq_tb.sv

//--- run.sh
#!/bin/sh
# build the simulator from tb.f, then run it
# the exit status of the run is the result

verilator --binary --timing --assert \
  -f tb.f \
  --top-module acq_tb \
  -o acq_sim \
  && ./obj_dir/acq_sim \
  || exit 1
